/* Makefile */
TOP := tb_rx_scheduler

all: run

build:
	verilator --binary --timing --assert -j 0 -f sim.f --top-module $(TOP) -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

lint:
	verilator --lint-only -Wall --timing --assert -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

/* sim.f */
source/sched_pkg.sv
source/slot_keeper.sv
source/core_selector.sv
source/host_cmd_regs.sv
source/port_arbiter.sv
source/port_desc_fsm.sv
source/rx_scheduler.sv
verification/rx_scheduler_chk.sv
verification/tb_rx_scheduler.sv

/* source/core_selector.sv */
`timescale 1ns/10ps

module core_selector import sched_pkg::*; #(
  parameter int core_count = core_count_def,
  parameter int slot_w     = sched_pkg::slot_w
) (
  input  slot_t [core_count-1:0] counts,
  input  logic  [core_count-1:0] valids,
  output core_id_t               core,
  output logic                   core_valid
);

  localparam int levels = (core_count > 1) ? $clog2(core_count) : 0;
  localparam int leaves = 1 << levels;
  localparam int nodes  = 2 * leaves - 1;

  // Heap layout, node n has children 2n+1 and 2n+2
  logic [slot_w-1:0] node_val [nodes];
  core_id_t          node_idx [nodes];
  logic              node_v   [nodes];

  always_comb begin
    for (int n = 0; n < nodes; n++) begin
      node_val[n] = '0;
      node_idx[n] = '0;
      node_v[n]   = 1'b0;
    end
    for (int i = 0; i < core_count; i++) begin
      node_val[leaves-1+i] = counts[i];
      node_idx[leaves-1+i] = core_id_t'(i);
      node_v[leaves-1+i]   = valids[i];
    end
    // Left child holds the lower indices, so it wins a tie
    for (int n = leaves - 2; n >= 0; n--) begin
      if (node_v[2*n+1] && (!node_v[2*n+2] || node_val[2*n+1] >= node_val[2*n+2])) begin
        node_val[n] = node_val[2*n+1];
        node_idx[n] = node_idx[2*n+1];
      end else begin
        node_val[n] = node_val[2*n+2];
        node_idx[n] = node_idx[2*n+2];
      end
      node_v[n] = node_v[2*n+1] || node_v[2*n+2];
    end
  end

  assign core       = node_idx[0];
  assign core_valid = node_v[0];

endmodule

/* source/host_cmd_regs.sv */
`timescale 1ns/10ps

module host_cmd_regs import sched_pkg::*; #(
  parameter int core_count = core_count_def,
  parameter int if_count   = if_count_def
) (
  input  logic                         clk,
  input  logic                         rst_r,
  input  host_cmd_t                    host_cmd,
  input  host_word_t                   host_wr_data,
  input  logic                         host_valid,
  input  slot_t       [core_count-1:0] slot_counts,
  input  port_state_t [if_count-1:0]   port_states,
  input  dest_tag_t   [if_count-1:0]   port_dests,
  output logic        [core_count-1:0] enabled_cores,
  output logic        [core_count-1:0] income_cores,
  output logic        [core_count-1:0] slots_flush,
  output host_word_t                   host_rd_data
);

  host_cmd_t   cmd_r;
  host_word_t  wr_data_r;
  host_word_t  rd_data_n;
  logic        wr_r;
  cmd_code_t   code;
  slot_t       sel_count;
  port_state_t sel_state;
  dest_tag_t   sel_dest;
  logic        core_in_range;
  logic        port_in_range;

  // Command stage, only writes aimed at the scheduler count
  always_ff @(posedge clk) begin
    if (rst_r) begin
      cmd_r <= '0;
      wr_r  <= 1'b0;
    end else begin
      wr_r <= host_valid && host_cmd.wr && host_cmd.sched;
      if (host_valid)
        cmd_r <= host_cmd;
    end
  end

  always_ff @(posedge clk) begin
    if (host_valid)
      wr_data_r <= host_wr_data;
  end

  assign code          = {cmd_r.if_not_core, cmd_r.regsel};
  assign core_in_range = int'(cmd_r.index) < core_count;
  assign port_in_range = int'(cmd_r.index) < if_count;
  assign sel_count     = slot_counts[core_id_t'(cmd_r.index)];
  assign sel_state     = port_states[port_id_t'(cmd_r.index)];
  assign sel_dest      = port_dests[port_id_t'(cmd_r.index)];

  always_ff @(posedge clk) begin
    if (rst_r) begin
      enabled_cores <= '0;
      income_cores  <= '0;
      slots_flush   <= '0;
    end else begin
      slots_flush <= '0;
      if (wr_r) begin
        case (code)
          reg_enable: begin
            // A disabled core cannot stay incoming
            income_cores  <= income_cores & wr_data_r[core_count-1:0];
            enabled_cores <= wr_data_r[core_count-1:0];
          end
          reg_income: income_cores <= wr_data_r[core_count-1:0] & enabled_cores;
          reg_flush:  slots_flush  <= wr_data_r[core_count-1:0];
          default: ;
        endcase
      end
    end
  end

  // Read path, two register stages
  always_ff @(posedge clk) begin
    case (code)
      reg_enable:     rd_data_n <= host_word_t'(enabled_cores);
      reg_income:     rd_data_n <= host_word_t'(income_cores);
      reg_slot_count: rd_data_n <= core_in_range ? host_word_t'(sel_count) : rd_default;
      reg_port_status:
        rd_data_n <= port_in_range ?
                     {14'd0, sel_state, {(8-core_id_w){1'b0}}, sel_dest.core,
                      {(8-slot_w){1'b0}}, sel_dest.slot} : rd_default;
      default:        rd_data_n <= rd_default;
    endcase
    host_rd_data <= rd_data_n;
  end

endmodule

/* source/port_arbiter.sv */
`timescale 1ns/10ps

module port_arbiter import sched_pkg::*; #(
  parameter int if_count = if_count_def
) (
  input  logic                clk,
  input  logic                rst_r,
  input  logic [if_count-1:0] request,
  input  logic                taken,
  output logic [if_count-1:0] grant,
  output logic                grant_valid,
  output port_id_t            grant_index
);

  logic [if_count-1:0] rr_mask;
  logic [if_count-1:0] cur_mask;
  logic [if_count-1:0] pick_from;
  logic [if_count-1:0] next_grant;
  logic                next_valid;
  port_id_t            next_index;

  always_comb begin
    // Ports above the one just served go first
    for (int i = 0; i < if_count; i++)
      cur_mask[i] = taken ? (i > int'(grant_index)) : rr_mask[i];
    pick_from  = ((request & cur_mask) != '0) ? (request & cur_mask) : request;
    next_valid = (pick_from != '0);
    next_index = '0;
    for (int i = if_count - 1; i >= 0; i--)
      if (pick_from[i])
        next_index = port_id_t'(i);
    for (int i = 0; i < if_count; i++)
      next_grant[i] = next_valid && (next_index == port_id_t'(i));
  end

  // Grant is held until a descriptor is actually taken
  always_ff @(posedge clk) begin
    if (rst_r) begin
      grant       <= '0;
      grant_valid <= 1'b0;
      grant_index <= '0;
      rr_mask     <= '1;
    end else begin
      if (taken || !grant_valid) begin
        grant       <= next_grant;
        grant_valid <= next_valid;
        grant_index <= next_index;
      end
      rr_mask <= cur_mask;
    end
  end

endmodule

/* source/port_desc_fsm.sv */
`timescale 1ns/10ps

module port_desc_fsm import sched_pkg::*; #(
  parameter int port_id = 0
) (
  input  logic        clk,
  input  logic        rst_r,
  input  logic        granted,
  input  dest_tag_t   desc_load,
  input  logic        desc_load_valid,
  input  logic        beat_fire,
  input  logic        beat_last,
  output logic        desc_req,
  output logic        not_stall,
  output dest_tag_t   cur_dest,
  output port_state_t state,
  output dest_tag_t   pend_dest
);

  port_state_t state_next;
  dest_tag_t   run_dest;
  logic        last_fire;

  // Port number has to fit the stamp on the output lane
  if (port_id >= (1 << port_w)) begin : g_id_chk
    $error("port_desc_fsm: port_id %0d does not fit in the port stamp", port_id);
  end

  assign last_fire = beat_fire && beat_last;

  always_comb begin
    state_next = state;
    case (state)
      // No descriptor yet, port is held
      ps_stall:
        if (desc_load_valid)
          state_next = ps_first;
      ps_first:
        if (last_fire)
          state_next = ps_stall;
        else if (beat_fire)
          state_next = ps_wait_desc;
      // Packet running, next descriptor still missing
      ps_wait_desc:
        if (desc_load_valid && last_fire)
          state_next = ps_first;
        else if (desc_load_valid)
          state_next = ps_mid;
        else if (last_fire)
          state_next = ps_stall;
      ps_mid:
        if (last_fire)
          state_next = ps_first;
      default: state_next = ps_stall;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_r)
      state <= ps_stall;
    else
      state <= state_next;
  end

  always_ff @(posedge clk) begin
    if (desc_load_valid)
      pend_dest <= desc_load;
    // Packet start consumes the pending descriptor
    if (state == ps_first && beat_fire)
      run_dest <= pend_dest;
  end

  assign desc_req  = !granted && ((state == ps_stall) || (state == ps_wait_desc) ||
                                  ((state == ps_first) && beat_fire));
  assign not_stall = (state != ps_stall);
  assign cur_dest  = (state == ps_first) ? pend_dest : run_dest;

endmodule

/* source/rx_scheduler.sv */
`timescale 1ns/10ps

module rx_scheduler import sched_pkg::*; #(
  parameter int if_count   = if_count_def,
  parameter int core_count = core_count_def,
  parameter int slot_count = slot_count_def,
  parameter int data_width = data_width_def
) (
  input  logic                      clk,
  input  logic                      rst_r,
  input  rx_beat_t  [if_count-1:0]  rx_beat,
  input  logic      [if_count-1:0]  rx_valid,
  output logic      [if_count-1:0]  rx_ready,
  output rx_beat_t  [if_count-1:0]  out_beat,
  output dest_tag_t [if_count-1:0]  out_dest,
  output port_id_t  [if_count-1:0]  out_port,
  output logic      [if_count-1:0]  out_valid,
  input  logic      [if_count-1:0]  out_ready,
  input  ctrl_msg_t                 ctrl_msg,
  input  logic                      ctrl_valid,
  input  host_cmd_t                 host_cmd,
  input  host_word_t                host_wr_data,
  input  logic                      host_valid,
  output host_word_t                host_rd_data
);

  logic        [core_count-1:0] enabled_cores;
  logic        [core_count-1:0] income_cores;
  logic        [core_count-1:0] slots_flush;
  logic        [core_count-1:0] enq_v;
  logic        [core_count-1:0] init_v;
  slot_t                        ctrl_slot_r;
  slot_t       [core_count-1:0] head_slot;
  slot_t       [core_count-1:0] free_count;
  logic        [core_count-1:0] head_valid;
  logic        [core_count-1:0] keeper_pop;
  logic        [core_count-1:0] keeper_mask;
  core_id_t                     sel_core;
  logic                         sel_valid;
  logic        [if_count-1:0]   desc_req;
  logic        [if_count-1:0]   grant;
  logic                         grant_valid;
  port_id_t                     grant_index;
  logic                         desc_pop;
  dest_tag_t                    desc_load;
  logic        [if_count-1:0]   not_stall;
  logic        [if_count-1:0]   beat_fire;
  port_state_t [if_count-1:0]   port_states;
  dest_tag_t   [if_count-1:0]   pend_dests;

  // Beat type is built for the default data width
  if (data_width != data_width_def) begin : g_width_chk
    $error("rx_scheduler: data_width %0d does not match the beat type", data_width);
  end

  host_cmd_regs #(
    .core_count(core_count),
    .if_count  (if_count)
  ) i_host_regs (
    .clk          (clk),
    .rst_r        (rst_r),
    .host_cmd     (host_cmd),
    .host_wr_data (host_wr_data),
    .host_valid   (host_valid),
    .slot_counts  (free_count),
    .port_states  (port_states),
    .port_dests   (pend_dests),
    .enabled_cores(enabled_cores),
    .income_cores (income_cores),
    .slots_flush  (slots_flush),
    .host_rd_data (host_rd_data)
  );

  // Control message decode, one registered strobe per core
  always_ff @(posedge clk) begin
    if (rst_r) begin
      enq_v  <= '0;
      init_v <= '0;
    end else begin
      for (int c = 0; c < core_count; c++) begin
        enq_v[c]  <= ctrl_valid && (ctrl_msg.msg_type == msg_slot_free) &&
                     (ctrl_msg.core == core_id_t'(c));
        init_v[c] <= ctrl_valid && (ctrl_msg.msg_type == msg_slot_init) &&
                     (ctrl_msg.core == core_id_t'(c));
      end
    end
  end

  always_ff @(posedge clk) begin
    ctrl_slot_r <= ctrl_msg.slot;
  end

  for (genvar c = 0; c < core_count; c++) begin : g_core
    assign keeper_pop[c] = desc_pop && (sel_core == core_id_t'(c));

    slot_keeper #(
      .max_slots(slot_count),
      .slot_w   (slot_w)
    ) i_keeper (
      .clk           (clk),
      .rst_r         (rst_r),
      .flush         (slots_flush[c]),
      .init_count    (ctrl_slot_r),
      .init_valid    (init_v[c]),
      .slot_in       (ctrl_slot_r),
      .slot_in_valid (enq_v[c]),
      .pop           (keeper_pop[c]),
      .slot_out      (head_slot[c]),
      .slot_out_valid(head_valid[c]),
      .slot_count    (free_count[c]),
      .enq_err       ()
    );
  end

  // Cores being flushed are left out of the choice
  assign keeper_mask = income_cores & enabled_cores & head_valid & ~slots_flush;

  core_selector #(
    .core_count(core_count),
    .slot_w    (slot_w)
  ) i_selector (
    .counts    (free_count),
    .valids    (keeper_mask),
    .core      (sel_core),
    .core_valid(sel_valid)
  );

  port_arbiter #(
    .if_count(if_count)
  ) i_arbiter (
    .clk        (clk),
    .rst_r      (rst_r),
    .request    (desc_req),
    .taken      (desc_pop),
    .grant      (grant),
    .grant_valid(grant_valid),
    .grant_index(grant_index)
  );

  assign desc_pop  = grant_valid && sel_valid;
  assign desc_load = '{core: sel_core, slot: head_slot[sel_core]};

  for (genvar i = 0; i < if_count; i++) begin : g_port
    port_desc_fsm #(
      .port_id(i)
    ) i_fsm (
      .clk            (clk),
      .rst_r          (rst_r),
      .granted        (grant[i]),
      .desc_load      (desc_load),
      .desc_load_valid(desc_pop && (grant_index == port_id_t'(i))),
      .beat_fire      (beat_fire[i]),
      .beat_last      (rx_beat[i].last),
      .desc_req       (desc_req[i]),
      .not_stall      (not_stall[i]),
      .cur_dest       (out_dest[i]),
      .state          (port_states[i]),
      .pend_dest      (pend_dests[i])
    );

    // Lane passes straight through while the port holds a descriptor
    assign out_valid[i] = rx_valid[i] && not_stall[i];
    assign rx_ready[i]  = out_ready[i] && not_stall[i];
    assign beat_fire[i] = rx_valid[i] && rx_ready[i];
    assign out_beat[i]  = rx_beat[i];
    assign out_port[i]  = port_id_t'(i);
  end

endmodule

/* source/sched_pkg.sv */
package sched_pkg;

  // Default sizes, overridden from the top level
  localparam int if_count_def   = 3;
  localparam int core_count_def = 4;
  localparam int slot_count_def = 8;
  localparam int data_width_def = 64;

  // Slot 0 is never handed out, hence the extra bit
  localparam int slot_w    = $clog2(slot_count_def + 1);
  localparam int core_id_w = $clog2(core_count_def);
  localparam int port_w    = $clog2(if_count_def);

  typedef logic [slot_w-1:0]    slot_t;
  typedef logic [core_id_w-1:0] core_id_t;
  typedef logic [port_w-1:0]    port_id_t;
  typedef logic [31:0]          host_word_t;
  typedef logic [4:0]           cmd_code_t;

  // Destination stamped on every packet
  typedef struct packed {
    core_id_t core;
    slot_t    slot;
  } dest_tag_t;

  typedef struct packed {
    logic [data_width_def-1:0]   data;
    logic [data_width_def/8-1:0] keep;
    logic                        last;
  } rx_beat_t;

  typedef struct packed {
    logic [3:0] msg_type;
    core_id_t   core;
    slot_t      slot;
  } ctrl_msg_t;

  typedef struct packed {
    logic       wr;
    logic       if_not_core;
    logic       sched;
    logic [3:0] index;
    logic [3:0] regsel;
  } host_cmd_t;

  typedef enum logic [1:0] {
    ps_stall     = 2'b00,
    ps_first     = 2'b01,
    ps_wait_desc = 2'b10,
    ps_mid       = 2'b11
  } port_state_t;

  // Control message types
  localparam logic [3:0] msg_slot_free = 4'd0;
  localparam logic [3:0] msg_slot_init = 4'd3;

  // Host register codes, interface flag in the top bit
  localparam cmd_code_t reg_enable      = 5'h00;
  localparam cmd_code_t reg_income      = 5'h01;
  localparam cmd_code_t reg_flush       = 5'h02;
  localparam cmd_code_t reg_slot_count  = 5'h03;
  localparam cmd_code_t reg_port_status = 5'h10;

  localparam host_word_t rd_default = 32'hFEFEFEFE;

endpackage

/* source/slot_keeper.sv */
`timescale 1ns/10ps

module slot_keeper import sched_pkg::*; #(
  parameter int max_slots = slot_count_def,
  parameter int slot_w    = sched_pkg::slot_w
) (
  input  logic  clk,
  input  logic  rst_r,
  input  logic  flush,
  input  slot_t init_count,
  input  logic  init_valid,
  input  slot_t slot_in,
  input  logic  slot_in_valid,
  input  logic  pop,
  output slot_t slot_out,
  output logic  slot_out_valid,
  output slot_t slot_count,
  output logic  enq_err
);

  localparam int ptr_w = (max_slots > 1) ? $clog2(max_slots) : 1;

  logic [slot_w-1:0] mem [max_slots];
  logic [ptr_w-1:0]  rd_ptr;
  logic [ptr_w-1:0]  wr_ptr;
  slot_t             count;
  slot_t             init_n;
  logic              full;
  logic              do_pop;
  logic              do_enq;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
    if (p == ptr_w'(max_slots - 1))
      return '0;
    return p + 1'b1;
  endfunction

  assign init_n = (int'(init_count) > max_slots) ? slot_t'(max_slots) : init_count;
  assign full   = (count == slot_t'(max_slots));
  assign do_pop = pop && (count != '0);
  assign do_enq = slot_in_valid && !full;

  always_ff @(posedge clk) begin
    if (rst_r || flush) begin
      rd_ptr  <= '0;
      wr_ptr  <= '0;
      count   <= '0;
      enq_err <= 1'b0;
    end else if (init_valid) begin
      // Buffer restarts holding slots 1 to N
      rd_ptr  <= '0;
      wr_ptr  <= (int'(init_n) == max_slots) ? '0 : ptr_w'(init_n);
      count   <= init_n;
      enq_err <= 1'b0;
    end else begin
      if (do_pop)
        rd_ptr <= next_ptr(rd_ptr);
      if (do_enq)
        wr_ptr <= next_ptr(wr_ptr);
      count   <= count + slot_t'(do_enq) - slot_t'(do_pop);
      enq_err <= slot_in_valid && full;
    end
  end

  always_ff @(posedge clk) begin
    if (init_valid) begin
      for (int i = 0; i < max_slots; i++)
        mem[i] <= slot_w'(i + 1);
    end else if (do_enq) begin
      mem[wr_ptr] <= slot_in;
    end
  end

  assign slot_out       = mem[rd_ptr];
  assign slot_out_valid = (count != '0);
  assign slot_count     = count;

endmodule

/* verification/rx_scheduler_chk.sv */
`timescale 1ns/10ps

module rx_scheduler_chk import sched_pkg::*; #(
  parameter int if_count   = if_count_def,
  parameter int core_count = core_count_def,
  parameter int slot_count = slot_count_def
) (
  input logic                        clk,
  input logic                        rst_r,
  input rx_beat_t    [if_count-1:0]   rx_beat,
  input logic        [if_count-1:0]   rx_valid,
  input logic        [if_count-1:0]   rx_ready,
  input logic        [if_count-1:0]   out_valid,
  input logic        [if_count-1:0]   out_ready,
  input rx_beat_t    [if_count-1:0]   out_beat,
  input dest_tag_t   [if_count-1:0]   out_dest,
  input port_id_t    [if_count-1:0]   out_port,
  input logic                        desc_pop,
  input port_id_t                    grant_index,
  input logic        [core_count-1:0] income_cores
);

  int fail_count = 0;

  for (genvar i = 0; i < if_count; i++) begin : g_lane
    logic pend_m;
    logic in_pkt_m;
    logic lane_open;
    logic in_fire;

    assign in_fire   = rx_valid[i] && rx_ready[i];
    assign lane_open = pend_m || in_pkt_m;

    // Expected port state, tracked from descriptor hand-outs and beats
    always_ff @(posedge clk) begin
      if (rst_r) begin
        pend_m   <= 1'b0;
        in_pkt_m <= 1'b0;
      end else begin
        if (desc_pop && grant_index == port_id_t'(i))
          pend_m <= 1'b1;
        else if (in_fire && !in_pkt_m)
          pend_m <= 1'b0;
        if (in_fire)
          in_pkt_m <= !rx_beat[i].last;
      end
    end

    // A port without a descriptor passes nothing
    a_stall_blocks: assert property (@(posedge clk) disable iff (rst_r)
      !lane_open |-> !out_valid[i] && !rx_ready[i])
      else begin
        fail_count++;
        $error("port %0d moved data without a descriptor", i);
      end

    a_ready_follows: assert property (@(posedge clk) disable iff (rst_r)
      lane_open |-> rx_ready[i] == out_ready[i] && out_valid[i] == rx_valid[i])
      else begin
        fail_count++;
        $error("port %0d handshake not passed through while holding a descriptor", i);
      end

    a_data_pass: assert property (@(posedge clk) disable iff (rst_r)
      out_valid[i] |-> out_beat[i] == rx_beat[i])
      else begin
        fail_count++;
        $error("port %0d beat changed on its way through", i);
      end

    a_port_stamp: assert property (@(posedge clk) disable iff (rst_r)
      out_valid[i] |-> out_port[i] == port_id_t'(i))
      else begin
        fail_count++;
        $error("MISMATCH out_port[%0d] got 0x%0h expected 0x%0h", i, out_port[i], i);
      end

    // Packet start must carry a usable destination
    a_first_dest: assert property (@(posedge clk) disable iff (rst_r)
      (out_valid[i] && out_ready[i] && !in_pkt_m) |->
      income_cores[out_dest[i].core] && out_dest[i].slot != '0 &&
      int'(out_dest[i].slot) <= slot_count)
      else begin
        fail_count++;
        $error("port %0d started a packet with a bad destination", i);
      end

    a_dest_held: assert property (@(posedge clk) disable iff (rst_r)
      $past(out_valid[i] && out_ready[i] && !out_beat[i].last) |->
      out_dest[i] == $past(out_dest[i]))
      else begin
        fail_count++;
        $error("port %0d destination changed inside a packet", i);
      end

    // Held beat under back-pressure
    a_bp_hold: assert property (@(posedge clk) disable iff (rst_r)
      $past(out_valid[i] && !out_ready[i]) |->
      out_valid[i] && out_beat[i] == $past(out_beat[i]) &&
      out_dest[i] == $past(out_dest[i]))
      else begin
        fail_count++;
        $error("port %0d dropped or changed a stalled beat", i);
      end
  end

endmodule

bind rx_scheduler rx_scheduler_chk #(
  .if_count  (if_count),
  .core_count(core_count),
  .slot_count(slot_count)
) i_chk (
  .clk         (clk),
  .rst_r       (rst_r),
  .rx_beat     (rx_beat),
  .rx_valid    (rx_valid),
  .rx_ready    (rx_ready),
  .out_valid   (out_valid),
  .out_ready   (out_ready),
  .out_beat    (out_beat),
  .out_dest    (out_dest),
  .out_port    (out_port),
  .desc_pop    (desc_pop),
  .grant_index (grant_index),
  .income_cores(income_cores)
);

/* verification/tb_rx_scheduler.sv */
`timescale 1ns/10ps

module tb_rx_scheduler import sched_pkg::*; ();

  localparam int if_count   = if_count_def;
  localparam int core_count = core_count_def;
  localparam int slot_count = slot_count_def;
  localparam int wait_limit = 200;
  localparam int poll_limit = 30;

  logic                       clk;
  logic                       rst_r;
  rx_beat_t  [if_count-1:0]   rx_beat;
  logic      [if_count-1:0]   rx_valid;
  logic      [if_count-1:0]   rx_ready;
  rx_beat_t  [if_count-1:0]   out_beat;
  dest_tag_t [if_count-1:0]   out_dest;
  port_id_t  [if_count-1:0]   out_port;
  logic      [if_count-1:0]   out_valid;
  logic      [if_count-1:0]   out_ready;
  ctrl_msg_t                  ctrl_msg;
  logic                       ctrl_valid;
  host_cmd_t                  host_cmd;
  host_word_t                 host_wr_data;
  logic                       host_valid;
  host_word_t                 host_rd_data;
  logic                       bp_on;
  logic      [31:0]           rng_state = 32'd24;
  int                         errors = 0;
  int                         last_total = 0;

  rx_scheduler #(
    .if_count  (if_count),
    .core_count(core_count),
    .slot_count(slot_count),
    .data_width(data_width_def)
  ) i_dut (
    .clk         (clk),
    .rst_r       (rst_r),
    .rx_beat     (rx_beat),
    .rx_valid    (rx_valid),
    .rx_ready    (rx_ready),
    .out_beat    (out_beat),
    .out_dest    (out_dest),
    .out_port    (out_port),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .ctrl_msg    (ctrl_msg),
    .ctrl_valid  (ctrl_valid),
    .host_cmd    (host_cmd),
    .host_wr_data(host_wr_data),
    .host_valid  (host_valid),
    .host_rd_data(host_rd_data)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function logic [31:0] rand_word();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Random sink back-pressure, roughly one stall in four
  initial begin
    out_ready = '1;
    forever begin
      @(negedge clk);
      for (int p = 0; p < if_count; p++)
        out_ready[p] = bp_on ? (rand_word() % 4 != 0) : 1'b1;
    end
  end

  task automatic send_ctrl(input logic [3:0] kind, input int core_n, input int slot_n);
    @(negedge clk);
    ctrl_msg   = '{msg_type: kind, core: core_id_t'(core_n), slot: slot_t'(slot_n)};
    ctrl_valid = 1'b1;
    @(negedge clk);
    ctrl_valid = 1'b0;
    // Keeper count settles two cycles after the strobe
    repeat (2) @(posedge clk);
  endtask

  task automatic host_write(input cmd_code_t code, input int index, input host_word_t data);
    @(negedge clk);
    host_cmd = '{wr: 1'b1, if_not_core: code[4], sched: 1'b1, index: 4'(index),
                 regsel: code[3:0]};
    host_wr_data = data;
    host_valid   = 1'b1;
    @(negedge clk);
    host_valid = 1'b0;
    repeat (2) @(posedge clk);
  endtask

  task automatic host_read(input cmd_code_t code, input int index, output host_word_t data);
    @(negedge clk);
    host_cmd = '{wr: 1'b0, if_not_core: code[4], sched: 1'b1, index: 4'(index),
                 regsel: code[3:0]};
    host_valid = 1'b1;
    @(posedge clk);
    @(negedge clk);
    host_valid = 1'b0;
    // Read data lands three cycles after the command
    repeat (2) @(posedge clk);
    @(negedge clk);
    data = host_rd_data;
  endtask

  task automatic check_value(input string what, input host_word_t got, input host_word_t exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s got 0x%08h expected 0x%08h", what, got, exp);
    end
  endtask

  task automatic check_read(input string what, input cmd_code_t code, input int index,
                            input host_word_t exp);
    host_word_t got;
    host_read(code, index, got);
    check_value(what, got, exp);
  endtask

  task automatic read_free_sum(output host_word_t sum);
    host_word_t cnt;
    sum = '0;
    for (int c = 0; c < core_count; c++) begin
      host_read(reg_slot_count, c, cnt);
      sum = sum + cnt;
    end
  endtask

  // Idle ports end up holding a pending descriptor
  task automatic wait_ports_loaded();
    host_word_t status;
    logic       loaded;
    for (int p = 0; p < if_count; p++) begin
      loaded = 1'b0;
      for (int n = 0; n < poll_limit && !loaded; n++) begin
        host_read(reg_port_status, p, status);
        loaded = (status[17:16] == ps_first);
      end
      if (!loaded) begin
        errors++;
        $display("port %0d never got its next descriptor", p);
      end
    end
  endtask

  task automatic send_packet(input int p, input int len);
    logic ok;
    logic fired;
    ok = 1'b1;
    for (int b = 0; b < len && ok; b++) begin
      @(negedge clk);
      rx_beat[p] = '{data: {rand_word(), rand_word()}, keep: '1, last: (b == len - 1)};
      rx_valid[p] = 1'b1;
      fired = 1'b0;
      for (int n = 0; n < wait_limit && !fired; n++) begin
        // Sample once inputs and ready have settled
        #1;
        fired = rx_ready[p];
        @(posedge clk);
        if (!fired)
          @(negedge clk);
      end
      if (!fired) begin
        errors++;
        ok = 1'b0;
        $display("port %0d beat %0d not accepted within %0d cycles", p, b, wait_limit);
      end
    end
    @(negedge clk);
    rx_valid[p] = 1'b0;
  endtask

  task automatic report_test(input int num, input string name);
    int total;
    total = errors + i_dut.i_chk.fail_count;
    $display("test %0d %s: %s", num, name, (total == last_total) ? "pass" : "fail");
    last_total = total;
  endtask

  initial begin
    host_word_t sum;
    int         total;
    rst_r        = 1'b1;
    rx_beat      = '0;
    rx_valid     = '0;
    ctrl_msg     = '0;
    ctrl_valid   = 1'b0;
    host_cmd     = '0;
    host_wr_data = '0;
    host_valid   = 1'b0;
    bp_on        = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_r = 1'b0;

    // No slots anywhere, every port must hold its beat
    @(negedge clk);
    for (int p = 0; p < if_count; p++)
      rx_beat[p] = '{data: {rand_word(), rand_word()}, keep: '1, last: 1'b0};
    rx_valid = '1;
    repeat (12) @(negedge clk);
    rx_valid = '0;
    report_test(1, "ports held without descriptors");

    send_ctrl(msg_slot_init, 1, 5);
    send_ctrl(msg_slot_init, 2, 3);
    host_write(reg_enable, 0, 32'hF);
    check_read("slot_count[1]", reg_slot_count, 1, 32'd5);
    check_read("slot_count[2]", reg_slot_count, 2, 32'd3);
    host_write(reg_income, 0, 32'h6);
    check_read("enabled_cores", reg_enable, 0, 32'hF);
    check_read("income_cores", reg_income, 0, 32'h6);
    report_test(2, "slot init and masks");

    // Three pending plus three started leaves two of eight
    fork
      send_packet(0, 1 + int'(rand_word() % 6));
      send_packet(1, 1 + int'(rand_word() % 6));
      send_packet(2, 1 + int'(rand_word() % 6));
    join
    wait_ports_loaded();
    read_free_sum(sum);
    check_value("free_slot_sum", sum, 32'd2);
    report_test(3, "packets with destinations");

    bp_on = 1'b1;
    fork
      send_packet(0, 2 + int'(rand_word() % 5));
      send_packet(1, 2 + int'(rand_word() % 5));
    join
    bp_on = 1'b0;
    wait_ports_loaded();
    read_free_sum(sum);
    check_value("free_slot_sum", sum, 32'd0);
    report_test(4, "back-pressure");

    // Core 1 was drained by the packets above
    send_ctrl(msg_slot_free, 1, 1);
    send_ctrl(msg_slot_free, 1, 3);
    send_ctrl(msg_slot_free, 1, 5);
    check_read("slot_count[1]", reg_slot_count, 1, 32'd3);
    host_write(reg_flush, 0, 32'h2);
    check_read("slot_count[1]", reg_slot_count, 1, 32'd0);
    host_write(reg_enable, 0, 32'h7);
    // Core 3 is disabled now and must not turn incoming
    host_write(reg_income, 0, 32'hA);
    check_read("enabled_cores", reg_enable, 0, 32'h7);
    check_read("income_cores", reg_income, 0, 32'h2);
    report_test(5, "slot return, flush and masking");

    check_read("host_rd_data", 5'h07, 0, rd_default);
    check_read("host_rd_data", reg_slot_count, 9, rd_default);
    report_test(6, "unassigned reads");

    total = errors + i_dut.i_chk.fail_count;
    $display("summary: 6 tests, %0d read errors or timeouts, %0d assertion failures",
             errors, i_dut.i_chk.fail_count);
    if (total == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule
